//--- Makefile
# Verilator build and run of the multiply/divide/root testbench
VERILATOR ?= verilator
TOP       ?= tb_top_mdr
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "Done: no errors" $(LOG); then echo "simulation stopped early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- mdr_datapath.sv
// arithmetic core of the multiply/divide/root unit
// AQ holds A (N+1 bits) over Q (N bits); one add/subtract serves all three ops
// result and remainder are taken from the last step and held until the next one
module mdr_datapath
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [1:0]            op_q,
	input  logic                  init,
	input  logic                  step,
	input  logic                  last_step,
	input  logic [mdr_pkg::N-1:0] x,
	input  logic [mdr_pkg::N-1:0] y,
	output logic [mdr_pkg::N-1:0] result,
	output logic [mdr_pkg::N-1:0] remainder
);

	logic [2*mdr_pkg::N:0] aq;  // {A, Q}
	logic [mdr_pkg::N-1:0] m;   // y for mul/div, shifting radicand for root
	logic                  qm1; // booth q[-1]

	logic [mdr_pkg::N:0]   a_cur;
	logic [mdr_pkg::N-1:0] q_cur;
	logic [mdr_pkg::N:0]   opa;
	logic [mdr_pkg::N:0]   opb;
	logic                  sub;
	logic [mdr_pkg::N:0]   sum;
	logic [mdr_pkg::N:0]   a_booth; // A after the booth add/sub, before the shift

	logic [mdr_pkg::N:0]   a_nxt;
	logic [mdr_pkg::N-1:0] q_nxt;
	logic [mdr_pkg::N-1:0] m_nxt;
	logic                  qm1_nxt;

	assign a_cur = aq[2*mdr_pkg::N:mdr_pkg::N];
	assign q_cur = aq[mdr_pkg::N-1:0];

	// ==================================================
	// shared adder operands
	// ==================================================
	always_comb
	begin
		opa = a_cur;
		opb = {m[mdr_pkg::N-1], m};
		sub = 1'b0;
		case (op_q)
			mdr_pkg::OP_MUL:
			begin
				sub = q_cur[0]; // pair 10 subtracts, pair 01 adds
			end
			mdr_pkg::OP_DIV:
			begin
				opa = {a_cur[mdr_pkg::N-1:0], q_cur[mdr_pkg::N-1]};
				opb = {1'b0, m};
				sub = 1'b1;
			end
			mdr_pkg::OP_SQRT:
			begin
				// next two radicand bits come from the top of m
				opa = {a_cur[mdr_pkg::N-2:0], m[mdr_pkg::N-1:mdr_pkg::N-2]};
				opb = {q_cur[mdr_pkg::N-2:0], 2'b01}; // 4*root + 1
				sub = 1'b1;
			end
			default:
			begin
				sub = 1'b0;
			end
		endcase
	end

	assign sum = sub ? (opa - opb) : (opa + opb);

	// booth leaves A alone on pairs 00 and 11
	assign a_booth = (q_cur[0] ^ qm1) ? sum : a_cur;

	// ==================================================
	// next step values
	// ==================================================
	always_comb
	begin
		a_nxt   = a_cur;
		q_nxt   = q_cur;
		m_nxt   = m;
		qm1_nxt = qm1;
		case (op_q)
			mdr_pkg::OP_MUL:
			begin
				// arithmetic right shift of {A, Q, q[-1]}
				a_nxt   = {a_booth[mdr_pkg::N], a_booth[mdr_pkg::N:1]};
				q_nxt   = {a_booth[0], q_cur[mdr_pkg::N-1:1]};
				qm1_nxt = q_cur[0];
			end
			mdr_pkg::OP_DIV, mdr_pkg::OP_SQRT:
			begin
				a_nxt = sum[mdr_pkg::N] ? opa : sum; // restore on negative
				q_nxt = {q_cur[mdr_pkg::N-2:0], ~sum[mdr_pkg::N]};
				if (op_q == mdr_pkg::OP_SQRT)
					m_nxt = {m[mdr_pkg::N-3:0], 2'b00};
			end
			default:
			begin
				a_nxt = a_cur;
			end
		endcase
	end

	// ==================================================
	// working registers
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (init)
		begin
			aq  <= '0;
			qm1 <= 1'b0;
			if (op_q == mdr_pkg::OP_SQRT)
				m <= x; // root builds up in Q from zero
			else
			begin
				aq[mdr_pkg::N-1:0] <= x;
				m                  <= y;
			end
		end
		else if (step)
		begin
			aq  <= {a_nxt, q_nxt};
			m   <= m_nxt;
			qm1 <= qm1_nxt;
		end
	end

	// output halves
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			result    <= '0;
			remainder <= '0;
		end
		else if (last_step)
		begin
			result    <= q_nxt;                  // product low, quotient or root
			remainder <= a_nxt[mdr_pkg::N-1:0]; // product high or remainder
		end
	end

endmodule

//--- mdr_display.sv
// seven-segment view of the result register
// multiply shows the 16-bit product, the other ops show result alone
module mdr_display
(
	input  logic [1:0]                                    op_q,
	input  logic [mdr_pkg::N-1:0]                         result,
	input  logic [mdr_pkg::N-1:0]                         remainder,
	output logic [mdr_pkg::TAM-1:0][mdr_pkg::SEG_W-1:0]   seg
);

	logic [2*mdr_pkg::N-1:0] value;
	logic [4*mdr_pkg::TAM-1:0] bcd; // digit 0 in the low nibble

	// ==================================================
	// bcd digit to segments, a in bit 6
	// ==================================================
	function automatic logic [mdr_pkg::SEG_W-1:0] to_seg(input logic [3:0] d);
		case (d)
			4'd0:    to_seg = 7'b1111110;
			4'd1:    to_seg = 7'b0110000;
			4'd2:    to_seg = 7'b1101101;
			4'd3:    to_seg = 7'b1111001;
			4'd4:    to_seg = 7'b0110011;
			4'd5:    to_seg = 7'b1011011;
			4'd6:    to_seg = 7'b1011111;
			4'd7:    to_seg = 7'b1110000;
			4'd8:    to_seg = 7'b1111111;
			4'd9:    to_seg = 7'b1111011;
			default: to_seg = 7'b0000001; // dash, never reached from double dabble
		endcase
	endfunction

	// product as a raw bit pattern
	assign value = (op_q == mdr_pkg::OP_MUL) ? {remainder, result}
	                                         : {{mdr_pkg::N{1'b0}}, result};

	// ==================================================
	// double dabble
	// ==================================================
	always_comb
	begin
		bcd = '0;
		for (int i = 2*mdr_pkg::N - 1; i >= 0; i--)
		begin
			// add 3 to any digit of 5 or more before the shift
			for (int d = 0; d < mdr_pkg::TAM; d++)
			begin
				if (bcd[4*d +: 4] > 4'd4)
					bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
			end
			bcd = {bcd[4*mdr_pkg::TAM-2:0], value[i]};
		end
	end

	always_comb
	begin
		for (int d = 0; d < mdr_pkg::TAM; d++)
			seg[d] = to_seg(bcd[4*d +: 4]);
	end

endmodule

//--- mdr_loader.sv
// operand capture for the multiply/divide/root unit
// the first load pulse writes x, the second writes y, a third starts a new pair
// loads are dropped while the unit is busy
module mdr_loader
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  load,
	input  logic                  busy,
	input  logic [mdr_pkg::N-1:0] data,
	output logic [mdr_pkg::N-1:0] x,
	output logic [mdr_pkg::N-1:0] y,
	output logic                  operands_ready
);

	logic sel;     // 0 steers the next load to x, 1 to y
	logic load_ok; // a load that is taken

	assign load_ok = load && !busy;

	// ==================================================
	// steering toggle and pair flag
	// ==================================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sel            <= 1'b0;
			operands_ready <= 1'b0;
		end
		else if (load_ok)
		begin
			sel            <= ~sel;
			operands_ready <= sel; // set by the y write, cleared by the next x write
		end
	end

	// ==================================================
	// operand registers
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (load_ok)
		begin
			if (!sel)
				x <= data;
			else
				y <= data;
		end
	end

endmodule

//--- mdr_pkg.sv
// shared widths, op codes and step counts for the multiply/divide/root unit
// every design file reaches these by scoped name, mdr_pkg::name
package mdr_pkg;

	// ==================================================
	// widths
	// ==================================================
	localparam int N     = 8;  // operand width
	localparam int C     = 4;  // iteration counter width
	localparam int TAM   = 5;  // display digits, enough for 65535
	localparam int SEG_W = 7;  // bit 6 is segment a, bit 0 is segment g

	// ==================================================
	// op codes
	// ==================================================
	localparam logic [1:0] OP_MUL  = 2'b00; // signed booth radix-2
	localparam logic [1:0] OP_DIV  = 2'b01; // unsigned restoring divide
	localparam logic [1:0] OP_SQRT = 2'b10; // unsigned restoring root of x
	localparam logic [1:0] OP_RSV  = 2'b11; // reserved, start ignored

	// ==================================================
	// step counts per op
	// ==================================================
	localparam logic [C-1:0] ITER_MUL  = C'(N);
	localparam logic [C-1:0] ITER_DIV  = C'(N);
	// two radicand bits go in on every root step
	localparam logic [C-1:0] ITER_SQRT = C'(N / 2);

endpackage

//--- mdr_sequencer.sv
// start/busy/done control for the multiply/divide/root unit
// latches op on an accepted start, pulses init, then runs one step per cycle
// until the down-counter for the latched op runs out
module mdr_sequencer
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       start,
	input  logic [1:0] op,
	input  logic       operands_ready,
	output logic [1:0] op_q,
	output logic       init,
	output logic       step,
	output logic       last_step,
	output logic       busy,
	output logic       done
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RUN,
		S_FINISH
	} state_t;

	state_t                state;
	logic [mdr_pkg::C-1:0] cnt;      // steps still to go
	logic [mdr_pkg::C-1:0] iter_sel; // step count for the incoming op
	logic                  accept;

	// only place where op validity and operand readiness are checked
	assign accept = start && (state != S_RUN) && operands_ready && (op != mdr_pkg::OP_RSV);

	always_comb
	begin
		case (op)
			mdr_pkg::OP_MUL: iter_sel = mdr_pkg::ITER_MUL;
			mdr_pkg::OP_DIV: iter_sel = mdr_pkg::ITER_DIV;
			default:         iter_sel = mdr_pkg::ITER_SQRT;
		endcase
	end

	// first run cycle loads the datapath, the rest are steps
	assign step      = (state == S_RUN) && !init;
	assign last_step = step && (cnt == mdr_pkg::C'(1));
	assign busy      = (state == S_RUN);
	assign done      = (state == S_FINISH); // one cycle, busy already low

	// ==================================================
	// state, counter, op latch
	// ==================================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= S_IDLE;
			cnt   <= '0;
			init  <= 1'b0;
			op_q  <= mdr_pkg::OP_MUL;
		end
		else
		begin
			init <= accept;
			case (state)
				S_RUN:
				begin
					if (last_step)
						state <= S_FINISH;
				end
				default: // idle or finish, a new start may come in either
				begin
					state <= accept ? S_RUN : S_IDLE;
				end
			endcase
			if (accept)
			begin
				op_q <= op;
				cnt  <= iter_sel;
			end
			else if (step)
				cnt <= cnt - mdr_pkg::C'(1);
		end
	end

endmodule

//--- sources.f
mdr_pkg.sv
mdr_loader.sv
mdr_sequencer.sv
mdr_datapath.sv
mdr_display.sv
top_mdr.sv
top_mdr_properties.sv
tb_top_mdr.sv

//--- tb_top_mdr.sv
// testbench for top_mdr: corner-case table, then LFSR operands, then handshake cases
// results, latency and display digits are checked against models of the arithmetic rules
module tb_top_mdr;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [1:0] MUL  = 2'b00;
	localparam logic [1:0] DIV  = 2'b01;
	localparam logic [1:0] SQRT = 2'b10;
	localparam logic [1:0] RSV  = 2'b11;

	localparam int NUM_ENTRIES    = 20;
	localparam int NUM_RANDOM     = 40;
	localparam int TIMEOUT_CYCLES = (NUM_ENTRIES + NUM_RANDOM) * 16 + 100;

	typedef struct packed {
		logic [1:0] op;
		logic [7:0] x;
		logic [7:0] y;
		logic [7:0] res;
		logic [7:0] rem;
	} vector_t;

	logic            clk = 1'b0;
	logic            arst_n;
	logic            load;
	logic            start;
	logic [1:0]      op;
	logic [7:0]      data;
	logic [7:0]      result;
	logic [7:0]      remainder;
	logic            busy;
	logic            done;
	logic [4:0][6:0] seg;
	int              cycles = 0;
	logic [31:0]     lfsr_state;

	// ==================================================
	// corner cases, expected values worked out by hand
	// ==================================================
	vector_t vectors [NUM_ENTRIES] = '{
		'{MUL,  8'h00, 8'h05, 8'h00, 8'h00}, // 0 * 5
		'{MUL,  8'h01, 8'hFF, 8'hFF, 8'hFF}, // 1 * -1
		'{MUL,  8'hFF, 8'hFF, 8'h01, 8'h00}, // -1 * -1
		'{MUL,  8'h80, 8'h80, 8'h00, 8'h40}, // -128 * -128 = 16384
		'{MUL,  8'h7F, 8'h80, 8'h80, 8'hC0}, // 127 * -128 = -16256
		'{MUL,  8'hF9, 8'h09, 8'hC1, 8'hFF}, // -7 * 9
		'{MUL,  8'h0C, 8'h0B, 8'h84, 8'h00}, // 12 * 11
		'{MUL,  8'h7F, 8'h7F, 8'h01, 8'h3F}, // 127 * 127
		'{DIV,  8'h25, 8'h00, 8'hFF, 8'h25}, // divide by zero
		'{DIV,  8'h05, 8'h09, 8'h00, 8'h05}, // x < y
		'{DIV,  8'h4D, 8'h4D, 8'h01, 8'h00}, // x = y
		'{DIV,  8'hFF, 8'h01, 8'hFF, 8'h00}, // 255 / 1
		'{DIV,  8'hC8, 8'h07, 8'h1C, 8'h04}, // 200 / 7
		'{DIV,  8'h00, 8'h03, 8'h00, 8'h00},
		'{SQRT, 8'h00, 8'h00, 8'h00, 8'h00},
		'{SQRT, 8'h01, 8'h00, 8'h01, 8'h00},
		'{SQRT, 8'h90, 8'h00, 8'h0C, 8'h00}, // 144
		'{SQRT, 8'hE1, 8'h00, 8'h0F, 8'h00}, // 225
		'{SQRT, 8'hFF, 8'h00, 8'h0F, 8'h1E}, // 255 = 15*15 + 30
		'{SQRT, 8'hC8, 8'h00, 8'h0E, 8'h04}  // 200 = 14*14 + 4
	};

	// digits 0 to 9, segment a in bit 6
	logic [6:0] seg_table [10] = '{
		7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001, 7'b0110011,
		7'b1011011, 7'b1011111, 7'b1110000, 7'b1111111, 7'b1111011
	};

	top_mdr dut_i
	(
		.clk       (clk),
		.arst_n    (arst_n),
		.load      (load),
		.start     (start),
		.op        (op),
		.data      (data),
		.result    (result),
		.remainder (remainder),
		.busy      (busy),
		.done      (done),
		.seg       (seg)
	);

	initial
	begin
		forever #4 clk = ~clk; // 8 ns period
	end

	// ==================================================
	// failure reporting and checks
	// ==================================================
	task automatic fail_run();
		$display("Done: errors found");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
			fail_run();
		end
	endtask

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT_CYCLES)
		begin
			$display("Timeout: the DUT gave no result within %0d cycles", TIMEOUT_CYCLES);
			fail_run();
		end
	end

	// ==================================================
	// stimulus source and reference models
	// ==================================================
	// fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		logic       fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v          = {v[6:0], fb};
		end
		return v;
	endfunction

	// returns {remainder, result}
	function automatic logic [15:0] expected_pair(input logic [1:0] o, input logic [7:0] a,
		input logic [7:0] b);
		int xi;
		int yi;
		int r;
		xi = int'(a);
		yi = int'(b);
		case (o)
			MUL:
			begin
				r = int'($signed(a)) * int'($signed(b));
				return r[15:0];
			end
			DIV:
			begin
				if (yi == 0)
					return {a, 8'hFF};
				return {8'(xi % yi), 8'(xi / yi)};
			end
			default:
			begin
				r = 0;
				while ((r + 1) * (r + 1) <= xi)
					r++;
				return {8'(xi - r * r), 8'(r)};
			end
		endcase
	endfunction

	task automatic check_display(input logic [1:0] o, input logic [7:0] res,
		input logic [7:0] rem);
		int value;
		int digit;
		value = (o == MUL) ? int'({rem, res}) : int'(res); // product as unsigned pattern
		for (int d = 0; d < 5; d++)
		begin
			digit = value % 10;
			value = value / 10;
			check_value($sformatf("seg[%0d]", d), 32'(seg[d]), 32'(seg_table[digit]));
		end
	endtask

	// ==================================================
	// bus actions, each starts and ends on a falling edge
	// ==================================================
	task automatic load_word(input logic [7:0] w);
		load = 1'b1;
		data = w;
		@(negedge clk);
		load = 1'b0;
	endtask

	task automatic launch(input logic [1:0] o, input logic [15:0] exp, input bit disturb);
		int lat;
		op    = o;
		start = 1'b1;
		@(negedge clk); // start taken at the rising edge just passed
		start = 1'b0;
		lat   = 0;
		while (!done)
		begin
			if (disturb && lat < 3) // load, start and a new op while busy
			begin
				load  = 1'b1;
				start = 1'b1;
				data  = ~data;
				op    = (o == MUL) ? DIV : MUL;
			end
			else
			begin
				load  = 1'b0;
				start = 1'b0;
			end
			@(negedge clk);
			lat++;
		end
		check_value("latency", 32'(lat), (o == SQRT) ? 32'd5 : 32'd9);
		check_value("result", 32'(result), 32'(exp[7:0]));
		check_value("remainder", 32'(remainder), 32'(exp[15:8]));
		check_display(o, exp[7:0], exp[15:8]);
	endtask

	task automatic no_busy_after_start(input logic [1:0] o);
		op    = o;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		repeat (12)
		begin
			check_value("busy", 32'(busy), 32'd0);
			@(negedge clk);
		end
	endtask

	// ==================================================
	// test sequence
	// ==================================================
	initial
	begin
		logic [1:0] r2;
		logic [1:0] rop;
		logic [7:0] rx;
		logic [7:0] ry;
		arst_n     = 1'b0;
		load       = 1'b0;
		start      = 1'b0;
		op         = MUL;
		data       = 8'h00;
		lfsr_state = 32'h25ce1ec4;
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);

		check_value("busy", 32'(busy), 32'd0);
		check_value("done", 32'(done), 32'd0);
		check_value("result", 32'(result), 32'd0);
		check_value("remainder", 32'(remainder), 32'd0);
		check_display(MUL, 8'h00, 8'h00); // shows 00000

		for (int i = 0; i < NUM_ENTRIES; i++)
		begin
			load_word(vectors[i].x);
			load_word(vectors[i].y);
			launch(vectors[i].op, {vectors[i].rem, vectors[i].res}, 1'b0);
		end

		for (int k = 0; k < NUM_RANDOM; k++)
		begin
			r2  = 2'(rand_bits(2));
			rop = (r2 == RSV) ? MUL : r2;
			rx  = rand_bits(8);
			ry  = rand_bits(8);
			load_word(rx);
			load_word(ry);
			launch(rop, expected_pair(rop, rx, ry), 1'b0);
		end

		load_word(8'd200);
		load_word(8'd7);
		launch(DIV, 16'h041C, 1'b1); // 200 / 7 = 28 rem 4, despite inputs while busy

		no_busy_after_start(RSV); // full pair held, op reserved
		load_word(8'd6);          // third load opens a new pair at x
		no_busy_after_start(MUL);
		load_word(8'hFB);
		launch(MUL, 16'hFFE2, 1'b0); // 6 * -5 = -30

		$display("Done: no errors");
		$finish;
	end

endmodule

//--- top_mdr.sv
// top of the 8-bit multiply/divide/root unit with seven-segment output
// load twice for x then y, pulse start with op, read result when done pulses
module top_mdr
(
	input  logic                                        clk,
	input  logic                                        arst_n,
	input  logic                                        load,
	input  logic                                        start,
	input  logic [1:0]                                  op,
	input  logic [mdr_pkg::N-1:0]                       data,
	output logic [mdr_pkg::N-1:0]                       result,
	output logic [mdr_pkg::N-1:0]                       remainder,
	output logic                                        busy,
	output logic                                        done,
	output logic [mdr_pkg::TAM-1:0][mdr_pkg::SEG_W-1:0] seg
);

	logic [mdr_pkg::N-1:0] x;
	logic [mdr_pkg::N-1:0] y;
	logic                  operands_ready;
	logic [1:0]            op_q;   // op of the running or last operation
	logic                  init;
	logic                  step;
	logic                  last_step;

	mdr_loader loader_i
	(
		.clk            (clk),
		.arst_n         (arst_n),
		.load           (load),
		.busy           (busy),
		.data           (data),
		.x              (x),
		.y              (y),
		.operands_ready (operands_ready)
	);

	mdr_sequencer sequencer_i
	(
		.clk            (clk),
		.arst_n         (arst_n),
		.start          (start),
		.op             (op),
		.operands_ready (operands_ready),
		.op_q           (op_q),
		.init           (init),
		.step           (step),
		.last_step      (last_step),
		.busy           (busy),
		.done           (done)
	);

	mdr_datapath datapath_i
	(
		.clk       (clk),
		.arst_n    (arst_n),
		.op_q      (op_q),
		.init      (init),
		.step      (step),
		.last_step (last_step),
		.x         (x),
		.y         (y),
		.result    (result),
		.remainder (remainder)
	);

	mdr_display display_i
	(
		.op_q      (op_q),
		.result    (result),
		.remainder (remainder),
		.seg       (seg)
	);

endmodule

//--- top_mdr_properties.sv
// concurrent checks on the start/busy/done handshake of top_mdr
// attached to every top_mdr instance by the bind at the end of this file
module top_mdr_properties
(
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic busy,
	input logic done
);
	timeunit 1ns;
	timeprecision 1ps;

	logic seen_start; // a start has been sampled since reset

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			seen_start <= 1'b0;
		else if (start)
			seen_start <= 1'b1;
	end

	// ==================================================
	// handshake and done timing
	// ==================================================
	done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
		else $error("done stayed high for two cycles");

	done_after_busy: assert property (@(posedge clk) disable iff (!arst_n) done |-> $past(busy))
		else $error("done without busy in the cycle before");

	busy_falls_with_done: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(busy) == $rose(done))
		else $error("busy fall and done rise are not on the same edge");

	quiet_before_start: assert property (@(posedge clk) disable iff (!arst_n)
		!seen_start |-> !busy && !done)
		else $error("busy or done before any start");

endmodule

bind top_mdr top_mdr_properties props_i
(
	.clk    (clk),
	.arst_n (arst_n),
	.start  (start),
	.busy   (busy),
	.done   (done)
);
